// File: build.f
+incdir+include
source/rs5_pkg.sv
source/regbank.sv
source/execute.sv
source/data_memory.sv
source/retire.sv
source/backend_top.sv
test/backend_tb.sv

// File: run_sim.sh
#!/bin/sh
# Compile the back end and its testbench with Verilator, run, and check the log.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module backend_tb -f build.f -o backend_sim

./obj_dir/backend_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "sim passed" sim.log; then
    exit 0
fi
exit 1

// File: include/backend_model.svh
`ifndef BACKEND_MODEL_SVH
`define BACKEND_MODEL_SVH

////////////////////
// Model state
////////////////////

    localparam int MODEL_WORDS = 256;

    logic [31:0] model_regs [32];
    logic [7:0]  model_mem  [MODEL_WORDS*4];
    // Two write-backs in flight.
    // Index 1 is the older.
    logic [1:0]  pend_wb;
    logic [4:0]  pend_rd   [2];
    logic [31:0] pend_data [2];
    // Expected write-backs as {rd, data}.
    logic [36:0] expect_q  [$];

////////////////////
// Expected results
////////////////////

    function automatic logic [31:0] model_alu(input RS5_pkg::iType_e op,
                                              input logic [31:0] a, input logic [31:0] b);
        logic [63:0] uu;
        logic [31:0] hi;
        logic [31:0] a_corr;
        logic [31:0] b_corr;
        uu     = 64'(a) * 64'(b);
        hi     = uu[63:32];
        // A negative operand reads 2**32 too high as unsigned.
        // Each such operand takes the other one off the high half.
        a_corr = a[31] ? b : 32'b0;
        b_corr = b[31] ? a : 32'b0;
        case (op)
            RS5_pkg::ADD:    return a + b;
            RS5_pkg::SUB:    return a - b;
            RS5_pkg::AND:    return a & b;
            RS5_pkg::OR:     return a | b;
            RS5_pkg::XOR:    return a ^ b;
            // Flipped sign bits turn the signed compare into an unsigned one.
            RS5_pkg::SLT:    return {31'b0, (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)};
            RS5_pkg::SLL:    return a << b[4:0];
            RS5_pkg::SRL:    return a >> b[4:0];
            RS5_pkg::MUL:    return uu[31:0];
            RS5_pkg::MULHU:  return hi;
            RS5_pkg::MULH:   return hi - a_corr - b_corr;
            // Only rs1 is signed here.
            RS5_pkg::MULHSU: return hi - a_corr;
            default:         return 32'b0;
        endcase
    endfunction

    // Byte address wraps at the memory size.
    function automatic logic [31:0] model_load(input RS5_pkg::iType_e op,
                                               input logic [31:0] addr);
        logic [9:0]  at;
        logic [15:0] half;
        at   = addr[9:0];
        half = {model_mem[at | 10'd1], model_mem[at]};
        case (op)
            RS5_pkg::LB:  return {{24{model_mem[at][7]}}, model_mem[at]};
            RS5_pkg::LBU: return {24'b0, model_mem[at]};
            RS5_pkg::LH:  return {{16{half[15]}}, half};
            RS5_pkg::LHU: return {16'b0, half};
            default:      return {model_mem[at + 3], model_mem[at + 2], half};
        endcase
    endfunction

    function automatic void model_store(input RS5_pkg::iType_e op,
                                        input logic [31:0] addr, input logic [31:0] data);
        int count;
        count = (op == RS5_pkg::SB) ? 1 : (op == RS5_pkg::SH) ? 2 : 4;
        for (int i = 0; i < count; i++) begin
            model_mem[addr[9:0] + i] = data[i*8 +: 8];
        end
    endfunction

    // Called once per rising edge with the sampled issue inputs.
    // Reads come first, then the write from two issues back lands.
    function automatic void model_step(input logic valid, input RS5_pkg::iType_e op,
                                       input logic [4:0] rs1, input logic [4:0] rs2,
                                       input logic [4:0] rd, input logic [31:0] imm);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] value;
        logic        is_mem;
        logic        wb;
        a      = (rs1 == 5'd0) ? 32'b0 : model_regs[rs1];
        b      = (rs2 == 5'd0) ? 32'b0 : model_regs[rs2];
        is_mem = op inside {RS5_pkg::LB, RS5_pkg::LBU, RS5_pkg::LH, RS5_pkg::LHU, RS5_pkg::LW};
        wb     = valid && rd != 5'd0
               && !(op inside {RS5_pkg::NOP, RS5_pkg::SB, RS5_pkg::SH, RS5_pkg::SW});
        value  = is_mem ? model_load(op, a + imm) : model_alu(op, a, b);
        if (valid && op inside {RS5_pkg::SB, RS5_pkg::SH, RS5_pkg::SW}) begin
            model_store(op, a + imm, b);
        end
        if (pend_wb[1]) begin
            model_regs[pend_rd[1]] = pend_data[1];
        end
        pend_wb      = {pend_wb[0], wb};
        pend_rd[1]   = pend_rd[0];
        pend_data[1] = pend_data[0];
        pend_rd[0]   = rd;
        pend_data[0] = value;
        if (wb) begin
            expect_q.push_back({rd, value});
        end
    endfunction

`endif

// File: test/backend_tb.sv
`timescale 1ns/1ps

module backend_tb;
    import RS5_pkg::*;

    `include "backend_model.svh"

////////////////////
// Test lengths
////////////////////

    localparam int RESET_LEN   = 3;
    localparam int IDLE_LEN    = 20;
    localparam int ALU_COUNT   = 300;
    localparam int STORE_COUNT = 48;
    // Stores and loads stay in the first 16 words.
    localparam int STORE_WORDS = 16;
    // Per word: 4 LB, 4 LBU, 2 LH, 2 LHU, 1 LW.
    localparam int LOAD_COUNT  = STORE_WORDS * 13;
    localparam int MUL_COUNT   = 80;
    localparam int QUIET_COUNT = 40;
    localparam int MIX_COUNT   = 400;
    localparam int DRAIN_LEN   = 8;
    // Mixed stream takes at most two cycles per instruction.
    localparam int CYCLE_LIMIT = RESET_LEN + IDLE_LEN + ALU_COUNT + STORE_COUNT + LOAD_COUNT
                               + MUL_COUNT + QUIET_COUNT + 2 + 2 * MIX_COUNT
                               + 6 * (DRAIN_LEN + 2) + 100;

    logic        clk;
    logic        rst_i;
    logic        issue_valid_i;
    iType_e      operation_i;
    logic [4:0]  rs1_i;
    logic [4:0]  rs2_i;
    logic [4:0]  rd_i;
    logic [31:0] imm_i;
    logic        retire_valid_o;
    logic [4:0]  retire_rd_o;
    logic [31:0] retire_data_o;

    integer seed = 32'h35e1_f4a3;
    int errors = 0;
    int checks = 0;
    int cycle_count = 0;

    backend_top #(.RV32(RV32M), .MEM_WORDS(256)) backend_top_inst (
        .clk, .rst_i, .issue_valid_i, .operation_i, .rs1_i, .rs2_i, .rd_i, .imm_i,
        .retire_valid_o, .retire_rd_o, .retire_data_o
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

////////////////////
// Helpers
////////////////////

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic logic [4:0] rand_reg(input int lo, input int span);
        return 5'(lo + rand_below(span));
    endfunction

    // Half the picks land on x28 to x31, which hold the extreme values.
    function automatic logic [4:0] mul_operand();
        logic [31:0] r;
        r = $random(seed);
        return r[4] ? (5'd28 + {3'b000, r[1:0]}) : {1'b0, r[3:0]};
    endfunction

    // Byte address aligned to the access width.
    function automatic logic [31:0] access_addr(input iType_e op, input int words);
        logic [31:0] byte_addr;
        byte_addr = 32'(rand_below(words) * 4 + rand_below(4));
        if (op inside {LH, LHU, SH}) begin
            byte_addr[0] = 1'b0;
        end else if (op inside {LW, SW}) begin
            byte_addr[1:0] = 2'b00;
        end
        return byte_addr;
    endfunction

    // Every byte of a word depends on the full word index.
    function automatic logic [31:0] fill_word(input logic [7:0] idx);
        return {idx ^ 8'hc3, ~idx, idx + 8'h5d, idx};
    endfunction

    // Memory and registers start from the same known state in DUT and model.
    task automatic preload_state();
        logic [31:0] value;
        logic [7:0]  widx;
        for (int w = 0; w < 256; w++) begin
            widx  = 8'(w);
            value = fill_word(widx);
            backend_top_inst.data_memory_inst.mem[w] = value;
            for (int b = 0; b < 4; b++) begin
                model_mem[{widx, 2'(b)}] = value[b*8 +: 8];
            end
        end
        model_regs[0] = 32'b0;
        for (int r = 1; r < 32; r++) begin
            case (r)
                28:      value = 32'h8000_0000;
                29:      value = 32'hffff_ffff;
                30:      value = 32'h7fff_ffff;
                31:      value = 32'h0000_0001;
                default: value = $random(seed);
            endcase
            backend_top_inst.regbank_inst.regs[r] = value;
            model_regs[r] = value;
        end
        pend_wb = 2'b00;
        expect_q.delete();
    endtask

    task automatic issue_instr(input iType_e op, input logic [4:0] rs1, input logic [4:0] rs2,
                               input logic [4:0] rd, input logic [31:0] imm);
        @(posedge clk);
        issue_valid_i <= 1'b1;
        operation_i   <= op;
        rs1_i         <= rs1;
        rs2_i         <= rs2;
        rd_i          <= rd;
        imm_i         <= imm;
    endtask

    task automatic issue_gap();
        @(posedge clk);
        issue_valid_i <= 1'b0;
    endtask

    // Memory operations use x0 as base, so the immediate is the address.
    task automatic issue_random_op(input iType_e op, input logic [4:0] rd);
        if (op inside {LB, LBU, LH, LHU, LW, SB, SH, SW}) begin
            issue_instr(op, 5'd0, rand_reg(1, 31), rd, access_addr(op, 256));
        end else begin
            issue_instr(op, rand_reg(0, 32), rand_reg(0, 32), rd, $random(seed));
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            $display("Fail %s: got 0x%08h expected 0x%08h", name, actual, expected);
            errors++;
        end
    endtask

    // Latency is two cycles, so a few idle cycles empty the pipeline.
    task automatic drain_pipeline();
        int waited;
        waited = 0;
        issue_gap();
        @(negedge clk);
        while (expect_q.size() != 0 && waited < DRAIN_LEN) begin
            @(negedge clk);
            waited++;
        end
        if (expect_q.size() != 0) begin
            $display("Error: %0d write-backs never appeared after the pipeline drained",
                     expect_q.size());
            errors++;
            expect_q.delete();
        end
    endtask

    task automatic report_test(input int num, input string name, input int start);
        $display("test %0d %s: %0d errors", num, name, errors - start);
    endtask

////////////////////
// Model and checker
////////////////////

    always @(posedge clk) begin
        model_step(issue_valid_i, operation_i, rs1_i, rs2_i, rd_i, imm_i);
    end

    // Write-back ports are stable around the falling edge.
    always @(negedge clk) begin : check_writeback
        logic [36:0] head;
        if (!rst_i && retire_valid_o) begin
            if (expect_q.size() == 0) begin
                $display("Error: write-back to x%0d with data 0x%08h when none was expected",
                         retire_rd_o, retire_data_o);
                errors++;
            end else begin
                head = expect_q.pop_front();
                check_value("retire_rd_o", {27'b0, retire_rd_o}, {27'b0, head[36:32]});
                check_value("retire_data_o", retire_data_o, head[31:0]);
            end
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Error: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("sim failed");
            $finish;
        end
    end

////////////////////
// Tests
////////////////////

    initial begin : run_tests
        int start;
        iType_e op;
        int kind;
        rst_i         = 1'b1;
        issue_valid_i = 1'b0;
        operation_i   = NOP;
        rs1_i         = 5'd0;
        rs2_i         = 5'd0;
        rd_i          = 5'd0;
        imm_i         = 32'b0;
        preload_state();
        repeat (RESET_LEN) @(posedge clk);
        rst_i <= 1'b0;

        // Nothing issued, nothing retires.
        start = errors;
        repeat (IDLE_LEN) issue_gap();
        drain_pipeline();
        report_test(1, "idle after reset", start);

        // Narrow register range makes stale reads frequent.
        start = errors;
        for (int i = 0; i < ALU_COUNT; i++) begin
            op = iType_e'(ADD + rand_below(8));
            issue_instr(op, rand_reg(0, 16), rand_reg(0, 16), rand_reg(1, 7), $random(seed));
        end
        drain_pipeline();
        report_test(2, "alu back to back", start);

        start = errors;
        for (int i = 0; i < STORE_COUNT; i++) begin
            op = iType_e'(SB + rand_below(3));
            issue_instr(op, 5'd0, rand_reg(1, 31), 5'd0, access_addr(op, STORE_WORDS));
        end
        // Every lane of every stored word, each load width.
        for (int w = 0; w < STORE_WORDS; w++) begin
            for (int lane = 0; lane < 4; lane++) begin
                issue_instr(LB, 5'd0, 5'd0, rand_reg(1, 15), 32'(w * 4 + lane));
                issue_instr(LBU, 5'd0, 5'd0, rand_reg(1, 15), 32'(w * 4 + lane));
            end
            for (int lane = 0; lane < 4; lane += 2) begin
                issue_instr(LH, 5'd0, 5'd0, rand_reg(1, 15), 32'(w * 4 + lane));
                issue_instr(LHU, 5'd0, 5'd0, rand_reg(1, 15), 32'(w * 4 + lane));
            end
            issue_instr(LW, 5'd0, 5'd0, rand_reg(1, 15), 32'(w * 4));
        end
        drain_pipeline();
        report_test(3, "stores then loads", start);

        start = errors;
        for (int i = 0; i < MUL_COUNT; i++) begin
            op = iType_e'(MUL + rand_below(4));
            issue_instr(op, mul_operand(), mul_operand(), rand_reg(1, 15), 32'b0);
        end
        drain_pipeline();
        report_test(4, "multiplies", start);

        // Stores, NOPs and rd zero must all stay off the write-back port.
        start = errors;
        for (int i = 0; i < QUIET_COUNT; i++) begin
            kind = rand_below(3);
            if (kind == 0) begin
                issue_random_op(iType_e'(SB + rand_below(3)), rand_reg(0, 32));
            end else if (kind == 1) begin
                issue_instr(NOP, rand_reg(0, 32), rand_reg(0, 32), rand_reg(0, 32),
                            $random(seed));
            end else begin
                issue_random_op(iType_e'(ADD + rand_below(20)), 5'd0);
            end
        end
        issue_instr(ADD, 5'd0, 5'd0, 5'd1, 32'b0);
        issue_instr(ADD, 5'd0, 5'd28, 5'd2, 32'b0);
        drain_pipeline();
        report_test(5, "no write-back cases", start);

        start = errors;
        for (int i = 0; i < MIX_COUNT; i++) begin
            if (rand_below(4) == 0) begin
                issue_gap();
            end
            issue_random_op(iType_e'(rand_below(21)), rand_reg(0, 32));
        end
        drain_pipeline();
        report_test(6, "mixed stream with gaps", start);

        $display("tests 6, checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// File: source/backend_top.sv
`timescale 1ns/1ps

module backend_top #(
    parameter RS5_pkg::rv32_e RV32      = RS5_pkg::RV32M,
    parameter int             MEM_WORDS = 256
) (
    input  logic                               clk,
    input  logic                               rst_i,
    input  logic                               issue_valid_i,
    input  RS5_pkg::iType_e                    operation_i,
    input  logic [RS5_pkg::REG_ADDR_W-1:0]     rs1_i,
    input  logic [RS5_pkg::REG_ADDR_W-1:0]     rs2_i,
    input  logic [RS5_pkg::REG_ADDR_W-1:0]     rd_i,
    input  logic [RS5_pkg::XLEN-1:0]           imm_i,
    output logic                               retire_valid_o,
    output logic [RS5_pkg::REG_ADDR_W-1:0]     retire_rd_o,
    output logic [RS5_pkg::XLEN-1:0]           retire_data_o
);
    import RS5_pkg::*;

    // Register bank read side.
    logic [REG_ADDR_W-1:0] rs1_addr;
    logic [REG_ADDR_W-1:0] rs2_addr;
    logic [XLEN-1:0]       rs1_data;
    logic [XLEN-1:0]       rs2_data;

    // Execute to memory.
    logic                  ex_valid;
    iType_e                ex_operation;
    logic [REG_ADDR_W-1:0] ex_rd;
    logic [XLEN-1:0]       ex_result;
    logic [XLEN-1:0]       ex_store_data;
    logic [2*XLEN-1:0]     ex_mul_result;
    logic [2*XLEN-1:0]     ex_mulh_result;
    logic [2*XLEN-1:0]     ex_mulhsu_result;

    // Memory to retire.
    logic                  mem_valid;
    iType_e                mem_operation;
    logic [REG_ADDR_W-1:0] mem_rd;
    logic [XLEN-1:0]       mem_result;
    logic [XLEN-1:0]       mem_data;
    logic [2*XLEN-1:0]     mem_mul_result;
    logic [2*XLEN-1:0]     mem_mulh_result;
    logic [2*XLEN-1:0]     mem_mulhsu_result;

    execute #(.RV32(RV32)) execute_inst (
        .clk, .rst_i, .issue_valid_i, .operation_i, .rs1_i, .rs2_i, .rd_i, .imm_i,
        .rs1_data_i(rs1_data), .rs2_data_i(rs2_data),
        .rs1_addr_o(rs1_addr), .rs2_addr_o(rs2_addr),
        .valid_o(ex_valid), .operation_o(ex_operation), .rd_o(ex_rd),
        .result_o(ex_result), .store_data_o(ex_store_data),
        .mul_result_o(ex_mul_result), .mulh_result_o(ex_mulh_result),
        .mulhsu_result_o(ex_mulhsu_result)
    );

    data_memory #(.MEM_WORDS(MEM_WORDS)) data_memory_inst (
        .clk, .rst_i,
        .valid_i(ex_valid), .operation_i(ex_operation), .rd_i(ex_rd),
        .result_i(ex_result), .store_data_i(ex_store_data),
        .mul_result_i(ex_mul_result), .mulh_result_i(ex_mulh_result),
        .mulhsu_result_i(ex_mulhsu_result),
        .valid_o(mem_valid), .operation_o(mem_operation), .rd_o(mem_rd),
        .result_o(mem_result), .mem_data_o(mem_data),
        .mul_result_o(mem_mul_result), .mulh_result_o(mem_mulh_result),
        .mulhsu_result_o(mem_mulhsu_result)
    );

    retire #(.RV32(RV32)) retire_inst (
        .clk,
        .valid_i(mem_valid), .operation_i(mem_operation), .rd_i(mem_rd),
        .result_i(mem_result), .mul_result_i(mem_mul_result),
        .mulh_result_i(mem_mulh_result), .mulhsu_result_i(mem_mulhsu_result),
        .mem_data_i(mem_data),
        .regbank_valid_o(retire_valid_o), .regbank_rd_o(retire_rd_o),
        .regbank_data_o(retire_data_o)
    );

    regbank regbank_inst (
        .clk, .rst_i,
        .rs1_addr_i(rs1_addr), .rs2_addr_i(rs2_addr),
        .rs1_data_o(rs1_data), .rs2_data_o(rs2_data),
        .write_i(retire_valid_o), .rd_i(retire_rd_o), .data_i(retire_data_o)
    );

endmodule

// File: source/retire.sv
`timescale 1ns/1ps

module retire #(
    parameter RS5_pkg::rv32_e RV32 = RS5_pkg::RV32M
) (
    input  logic                               clk,
    input  logic                               valid_i,
    input  RS5_pkg::iType_e                    operation_i,
    input  logic [RS5_pkg::REG_ADDR_W-1:0]     rd_i,
    input  logic [RS5_pkg::XLEN-1:0]           result_i,
    input  logic [2*RS5_pkg::XLEN-1:0]         mul_result_i,
    input  logic [2*RS5_pkg::XLEN-1:0]         mulh_result_i,
    input  logic [2*RS5_pkg::XLEN-1:0]         mulhsu_result_i,
    input  logic [RS5_pkg::XLEN-1:0]           mem_data_i,
    output logic                               regbank_valid_o,
    output logic [RS5_pkg::REG_ADDR_W-1:0]     regbank_rd_o,
    output logic [RS5_pkg::XLEN-1:0]           regbank_data_o
);
    import RS5_pkg::*;

    logic [7:0]      load_byte;
    logic [15:0]     load_half;
    logic [XLEN-1:0] load_data;

////////////////////
// Load alignment
////////////////////

    // Lane picked by the low bits of the byte address.
    assign load_byte = mem_data_i[{result_i[1:0], 3'b000} +: 8];
    assign load_half = mem_data_i[{result_i[1], 4'b0000} +: 16];

    always_comb begin
        case (operation_i)
            LB:      load_data = {{(XLEN-8){load_byte[7]}}, load_byte};
            LBU:     load_data = {{(XLEN-8){1'b0}}, load_byte};
            LH:      load_data = {{(XLEN-16){load_half[15]}}, load_half};
            LHU:     load_data = {{(XLEN-16){1'b0}}, load_half};
            default: load_data = mem_data_i;
        endcase
    end

////////////////////
// Write-back
////////////////////

    if (RV32 == RV32M || RV32 == RV32ZMMUL) begin : gen_mul_wb
        always_comb begin
            case (operation_i)
                LB, LBU, LH, LHU, LW: regbank_data_o = load_data;
                // Low half is the same for every signedness.
                MUL:     regbank_data_o = mul_result_i[XLEN-1:0];
                MULHU:   regbank_data_o = mul_result_i[2*XLEN-1:XLEN];
                MULH:    regbank_data_o = mulh_result_i[2*XLEN-1:XLEN];
                MULHSU:  regbank_data_o = mulhsu_result_i[2*XLEN-1:XLEN];
                default: regbank_data_o = result_i;
            endcase
        end
    end else begin : gen_base_wb
        // Without multiplies, execute already gave zero.
        assign regbank_data_o = (operation_i inside {LB, LBU, LH, LHU, LW})
                              ? load_data
                              : result_i;
    end

    // Stores and NOP write nothing; x0 is never written.
    assign regbank_valid_o = valid_i && (rd_i != '0)
                           && !(operation_i inside {NOP, SB, SH, SW});
    assign regbank_rd_o    = rd_i;

    // Operation issued upstream must still be a defined encoding here.
    a_known_operation: assert property (@(posedge clk)
        valid_i |-> !$isunknown(operation_i) && operation_i <= MULHU);

endmodule

// File: source/data_memory.sv
`timescale 1ns/1ps

module data_memory #(
    parameter int MEM_WORDS = 256
) (
    input  logic                               clk,
    input  logic                               rst_i,
    input  logic                               valid_i,
    input  RS5_pkg::iType_e                    operation_i,
    input  logic [RS5_pkg::REG_ADDR_W-1:0]     rd_i,
    input  logic [RS5_pkg::XLEN-1:0]           result_i,
    input  logic [RS5_pkg::XLEN-1:0]           store_data_i,
    input  logic [2*RS5_pkg::XLEN-1:0]         mul_result_i,
    input  logic [2*RS5_pkg::XLEN-1:0]         mulh_result_i,
    input  logic [2*RS5_pkg::XLEN-1:0]         mulhsu_result_i,
    output logic                               valid_o,
    output RS5_pkg::iType_e                    operation_o,
    output logic [RS5_pkg::REG_ADDR_W-1:0]     rd_o,
    output logic [RS5_pkg::XLEN-1:0]           result_o,
    output logic [RS5_pkg::XLEN-1:0]           mem_data_o,
    output logic [2*RS5_pkg::XLEN-1:0]         mul_result_o,
    output logic [2*RS5_pkg::XLEN-1:0]         mulh_result_o,
    output logic [2*RS5_pkg::XLEN-1:0]         mulhsu_result_o
);
    import RS5_pkg::*;

    localparam int IDX_W = $clog2(MEM_WORDS);

    logic [XLEN-1:0] mem [MEM_WORDS];
    logic [IDX_W-1:0] word_idx;
    logic [3:0]       byte_en;
    logic [XLEN-1:0]  write_data;

    // Upper address bits are dropped, so the index wraps.
    assign word_idx = result_i[IDX_W+1:2];

////////////////////
// Byte lanes
////////////////////

    // Lane select from the low address bits.
    // Data is replicated so every lane sees its byte.
    always_comb begin
        case (operation_i)
            SB: begin
                byte_en    = 4'b0001 << result_i[1:0];
                write_data = {4{store_data_i[7:0]}};
            end
            SH: begin
                byte_en    = result_i[1] ? 4'b1100 : 4'b0011;
                write_data = {2{store_data_i[15:0]}};
            end
            SW: begin
                byte_en    = 4'b1111;
                write_data = store_data_i;
            end
            default: begin
                byte_en    = 4'b0000;
                write_data = store_data_i;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (valid_i) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (byte_en[lane]) begin
                    mem[word_idx][lane*8 +: 8] <= write_data[lane*8 +: 8];
                end
            end
        end
        // Registered whole-word read, retire aligns it.
        mem_data_o <= mem[word_idx];
    end

////////////////////
// Stage register
////////////////////

    always_ff @(posedge clk) begin
        if (rst_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_i;
        end
    end

    always_ff @(posedge clk) begin
        operation_o     <= operation_i;
        rd_o            <= rd_i;
        result_o        <= result_i;
        mul_result_o    <= mul_result_i;
        mulh_result_o   <= mulh_result_i;
        mulhsu_result_o <= mulhsu_result_i;
    end

    // Address from execute must be aligned to the access width.
    a_half_aligned: assert property (@(posedge clk) disable iff (rst_i)
        valid_i && operation_i inside {LH, LHU, SH} |-> result_i[0] == 1'b0);
    a_word_aligned: assert property (@(posedge clk) disable iff (rst_i)
        valid_i && operation_i inside {LW, SW} |-> result_i[1:0] == 2'b00);

endmodule

// File: source/execute.sv
`timescale 1ns/1ps

module execute #(
    parameter RS5_pkg::rv32_e RV32 = RS5_pkg::RV32M
) (
    input  logic                               clk,
    input  logic                               rst_i,
    input  logic                               issue_valid_i,
    input  RS5_pkg::iType_e                    operation_i,
    input  logic [RS5_pkg::REG_ADDR_W-1:0]     rs1_i,
    input  logic [RS5_pkg::REG_ADDR_W-1:0]     rs2_i,
    input  logic [RS5_pkg::REG_ADDR_W-1:0]     rd_i,
    input  logic [RS5_pkg::XLEN-1:0]           imm_i,
    input  logic [RS5_pkg::XLEN-1:0]           rs1_data_i,
    input  logic [RS5_pkg::XLEN-1:0]           rs2_data_i,
    output logic [RS5_pkg::REG_ADDR_W-1:0]     rs1_addr_o,
    output logic [RS5_pkg::REG_ADDR_W-1:0]     rs2_addr_o,
    output logic                               valid_o,
    output RS5_pkg::iType_e                    operation_o,
    output logic [RS5_pkg::REG_ADDR_W-1:0]     rd_o,
    output logic [RS5_pkg::XLEN-1:0]           result_o,
    output logic [RS5_pkg::XLEN-1:0]           store_data_o,
    output logic [2*RS5_pkg::XLEN-1:0]         mul_result_o,
    output logic [2*RS5_pkg::XLEN-1:0]         mulh_result_o,
    output logic [2*RS5_pkg::XLEN-1:0]         mulhsu_result_o
);
    import RS5_pkg::*;

    logic [XLEN-1:0]   alu_result;
    logic [2*XLEN-1:0] mul_product;
    logic [2*XLEN-1:0] mulh_product;
    logic [2*XLEN-1:0] mulhsu_product;

    // Bank is read in the issue cycle, no bypass.
    assign rs1_addr_o = rs1_i;
    assign rs2_addr_o = rs2_i;

////////////////////
// ALU and AGU
////////////////////

    always_comb begin
        case (operation_i)
            ADD:     alu_result = rs1_data_i + rs2_data_i;
            SUB:     alu_result = rs1_data_i - rs2_data_i;
            AND:     alu_result = rs1_data_i & rs2_data_i;
            OR:      alu_result = rs1_data_i | rs2_data_i;
            XOR:     alu_result = rs1_data_i ^ rs2_data_i;
            // Signed compare, result in bit 0.
            SLT:     alu_result = {{(XLEN-1){1'b0}}, $signed(rs1_data_i) < $signed(rs2_data_i)};
            // Shift amount is the low five bits.
            SLL:     alu_result = rs1_data_i << rs2_data_i[4:0];
            SRL:     alu_result = rs1_data_i >> rs2_data_i[4:0];
            // Byte address for memory accesses.
            LB, LBU, LH, LHU, LW,
            SB, SH, SW: alu_result = rs1_data_i + imm_i;
            // Multiplies, NOP and anything unknown.
            default: alu_result = '0;
        endcase
    end

////////////////////
// Multiplier
////////////////////

    if (RV32 == RV32M || RV32 == RV32ZMMUL) begin : gen_mul
        // Full 64-bit products; retire picks the half.
        assign mul_product    = {{XLEN{1'b0}}, rs1_data_i} * {{XLEN{1'b0}}, rs2_data_i};
        assign mulh_product   = {{XLEN{rs1_data_i[XLEN-1]}}, rs1_data_i}
                              * {{XLEN{rs2_data_i[XLEN-1]}}, rs2_data_i};
        // Signed times unsigned, rs2 zero extended.
        assign mulhsu_product = {{XLEN{rs1_data_i[XLEN-1]}}, rs1_data_i}
                              * {{XLEN{1'b0}}, rs2_data_i};
    end else begin : gen_no_mul
        assign mul_product    = '0;
        assign mulh_product   = '0;
        assign mulhsu_product = '0;
    end

////////////////////
// Stage register
////////////////////

    always_ff @(posedge clk) begin
        if (rst_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= issue_valid_i;
        end
    end

    // Payload follows the valid bit.
    always_ff @(posedge clk) begin
        operation_o     <= operation_i;
        rd_o            <= rd_i;
        result_o        <= alu_result;
        store_data_o    <= rs2_data_i;
        mul_result_o    <= mul_product;
        mulh_result_o   <= mulh_product;
        mulhsu_result_o <= mulhsu_product;
    end

endmodule

// File: source/regbank.sv
`timescale 1ns/1ps

module regbank (
    input  logic                               clk,
    input  logic                               rst_i,
    input  logic [RS5_pkg::REG_ADDR_W-1:0]     rs1_addr_i,
    input  logic [RS5_pkg::REG_ADDR_W-1:0]     rs2_addr_i,
    output logic [RS5_pkg::XLEN-1:0]           rs1_data_o,
    output logic [RS5_pkg::XLEN-1:0]           rs2_data_o,
    input  logic                               write_i,
    input  logic [RS5_pkg::REG_ADDR_W-1:0]     rd_i,
    input  logic [RS5_pkg::XLEN-1:0]           data_i
);
    import RS5_pkg::*;

    // Entries are not cleared by reset.
    logic [XLEN-1:0] regs [2**REG_ADDR_W];

    // Write at the end of retire.
    // Held off during reset, while the pipeline is flushing.
    always_ff @(posedge clk) begin
        if (!rst_i && write_i && rd_i != '0) begin
            regs[rd_i] <= data_i;
        end
    end

    // Asynchronous reads.
    // x0 always reads zero.
    assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

endmodule

// File: source/rs5_pkg.sv
package RS5_pkg;

////////////////////
// Widths
////////////////////

    // Data path width.
    localparam int XLEN = 32;

    // Register number width, 32 architectural registers.
    localparam int REG_ADDR_W = 5;

////////////////////
// Operations
////////////////////

    // Decoded operations reaching the back end.
    // Five bits cover the 21 encodings below.
    typedef enum logic [4:0] {
        NOP,
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLT,
        SLL,
        SRL,
        LB,
        LBU,
        LH,
        LHU,
        LW,
        SB,
        SH,
        SW,
        MUL,
        MULH,
        MULHSU,
        MULHU
    } iType_e;

    // ISA variants.
    // RV32ZMMUL has the multiplies of RV32M but no division.
    typedef enum logic [1:0] {
        RV32I,
        RV32M,
        RV32ZMMUL
    } rv32_e;

endpackage
